/* common/cop_defines.svh */
// Co-processor global widths
`ifndef COP_DEFINES_SVH
`define COP_DEFINES_SVH

// Data word width in bits
`define COP_XLEN   32

// Number of co-processor registers
`define COP_NCPR   16

// Co-processor register address width
`define COP_CPR_AW 4

// CPU general purpose register address width
`define COP_GPR_AW 5

// Major opcode of all co-processor instructions
`define COP_OPCODE 7'h0B

`endif

/* common/cop_isa_pkg.sv */
// Co-processor instruction set types
`include "cop_defines.svh"

package cop_isa_pkg;

    typedef logic [`COP_XLEN-1:0]   word_t;     // One data word
    typedef logic [`COP_CPR_AW-1:0] cpr_addr_t; // COP register index
    typedef logic [`COP_GPR_AW-1:0] gpr_addr_t; // CPU GPR index

    typedef enum logic [3:0] {
        PACKED_ARITH = 4'd0,
        BITWISE      = 4'd1,
        MOVE         = 4'd2,
        LOADSTORE    = 4'd3
    } iclass_e;

    typedef enum logic [4:0] {
        ADD     = 5'd0,
        SUB     = 5'd1,
        AND     = 5'd2,
        OR      = 5'd3,
        XOR     = 5'd4,
        GPR2XCR = 5'd5, // GPR into COP register
        XCR2GPR = 5'd6, // COP register into GPR
        LW      = 5'd7,
        SW      = 5'd8
    } subop_e;

    typedef enum logic [1:0] {
        PW32 = 2'd0,
        PW16 = 2'd1,
        PW8  = 2'd2     // 2'd3 is illegal
    } pw_e;

    typedef enum logic [2:0] {
        SUCCESS = 3'd0,
        BAD_INS = 3'd1,
        BAD_LAD = 3'd2,
        BAD_SAD = 3'd3,
        LD_ERR  = 3'd4,
        ST_ERR  = 3'd5
    } result_e;

    typedef enum logic [1:0] {
        IDLE,
        WAITING,
        EXECUTING,
        FINISHED
    } fsm_e;

    // Raw instruction word layout
    typedef struct packed {
        logic [3:0] iclass; // 31:28
        logic [4:0] subop;  // 27:23
        logic       spare;  // 22
        logic [1:0] pw;     // 21:20
        cpr_addr_t  crs2;   // 19:16, also word offset
        cpr_addr_t  crs1;   // 15:12
        gpr_addr_t  rd;     // 11:7, crd in 10:7
        logic [6:0] opcode; // 6:0
    } insn_t;

    // Decoded micro-op
    typedef struct packed {
        logic      exception;
        iclass_e   iclass;
        subop_e    subop;
        pw_e       pw;
        cpr_addr_t crs1;
        cpr_addr_t crs2;
        cpr_addr_t crd;
        gpr_addr_t rd;
        logic [3:0] offset; // Load/store word offset
        word_t     gpr_rs1;
    } cop_uop_t;

endpackage

/* common/cop_bus_pkg.sv */
// Co-processor bus structures
package cop_bus_pkg;

    import cop_isa_pkg::*;

    // CPU to COP instruction request
    typedef struct packed {
        word_t enc;
        word_t rs1;
    } cpu_req_t;

    // COP to CPU instruction response
    typedef struct packed {
        logic      wen;
        gpr_addr_t waddr;
        word_t     wdata;
        result_e   result;
    } cpu_rsp_t;

    // Word memory request
    typedef struct packed {
        logic  cen;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // Word memory response
    typedef struct packed {
        word_t rdata;
        logic  stall;
        logic  error;
    } mem_rsp_t;

    // COP register file write port
    typedef struct packed {
        logic      wen;
        cpr_addr_t addr;
        word_t     wdata;
    } cpr_wr_t;

endpackage

/* issue/cop_issue.sv */
// Instruction issue and control
`timescale 1ns/1ps
`include "cop_defines.svh"

module cop_issue (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  cpu_insn_req, // CPU offers instruction
    output logic                  cop_insn_ack, // Ready to accept
    input  cop_bus_pkg::cpu_req_t cpu_req,
    input  logic                  cpu_insn_ack, // CPU takes response
    output logic                  cop_insn_rsp, // Response valid
    input  logic                  lsu_done,     // Load/store completes
    output cop_isa_pkg::cop_uop_t uop,
    output logic                  palu_valid,
    output logic                  lsu_valid,
    output logic                  bad_valid,
    output logic                  insn_finish
);

    import cop_isa_pkg::*;
    import cop_bus_pkg::*;

    cpu_req_t req_q;        // Latched request
    cpu_req_t req_u;        // Live in accept cycle, else latched
    insn_t    insn;
    logic     insn_accept;
    logic     insn_retired;
    logic     insn_valid;   // Instruction being executed
    logic     opc_ok, cls_ok, sub_ok, pw_ok;
    fsm_e     state_q, state_d;
    logic     ack_d, rsp_d;

    assign insn_accept  = cpu_insn_req && cop_insn_ack;
    assign insn_retired = cop_insn_rsp && cpu_insn_ack;
    assign req_u        = insn_accept ? cpu_req : req_q;
    assign insn         = insn_t'(req_u.enc);

    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            req_q <= cpu_req; // Held for multi-cycle loads/stores
        end
    end

    // Decode and legality
    always_comb begin
        opc_ok = insn.opcode == `COP_OPCODE;
        pw_ok  = insn.pw != 2'b11;
        cls_ok = 1'b1;
        sub_ok = 1'b0;
        case (insn.iclass)
            PACKED_ARITH: sub_ok = insn.subop inside {ADD, SUB};
            BITWISE:      sub_ok = insn.subop inside {AND, OR, XOR};
            MOVE:         sub_ok = insn.subop inside {GPR2XCR, XCR2GPR};
            LOADSTORE:    sub_ok = insn.subop inside {LW, SW};
            default:      cls_ok = 1'b0; // Unknown class
        endcase
    end

    always_comb begin
        uop.exception = !(opc_ok && cls_ok && sub_ok && pw_ok);
        uop.iclass    = iclass_e'(insn.iclass);
        uop.subop     = subop_e'(insn.subop);
        uop.pw        = pw_e'(insn.pw);
        uop.crs1      = insn.crs1;
        uop.crs2      = insn.crs2;
        uop.crd       = insn.rd[3:0];
        uop.rd        = insn.rd;
        uop.offset    = insn.crs2;   // Same field as crs2
        uop.gpr_rs1   = req_u.rs1;
    end

    // Dispatch
    assign insn_valid  = insn_accept || (state_q == EXECUTING);
    assign bad_valid   = insn_valid && uop.exception;
    assign palu_valid  = insn_valid && !uop.exception && (uop.iclass != LOADSTORE);
    assign lsu_valid   = insn_valid && !uop.exception && (uop.iclass == LOADSTORE);
    assign insn_finish = palu_valid || bad_valid || lsu_done;

    // Control machine
    always_comb begin
        state_d = state_q;
        ack_d   = 1'b0;
        rsp_d   = 1'b0;
        case (state_q)
            IDLE: begin
                state_d = WAITING;
                ack_d   = 1'b1;
            end
            WAITING: begin
                if (insn_accept && insn_finish) begin
                    state_d = FINISHED; // Single cycle op
                    rsp_d   = 1'b1;
                end else if (insn_accept) begin
                    state_d = EXECUTING;
                end else begin
                    ack_d   = 1'b1;
                end
            end
            EXECUTING: begin
                if (insn_finish) begin
                    state_d = FINISHED;
                    rsp_d   = 1'b1;
                end
            end
            default: begin // FINISHED
                if (insn_retired) begin
                    state_d = WAITING;
                    ack_d   = 1'b1;
                end else begin
                    rsp_d   = 1'b1; // Hold under back-pressure
                end
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q      <= IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
        end else begin
            state_q      <= state_d;
            cop_insn_ack <= ack_d;
            cop_insn_rsp <= rsp_d;
        end
    end

    // One instruction in flight at a time
    a_ack_rsp_excl: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp));

endmodule

/* exec/cop_cprs.sv */
// Co-processor register file
`timescale 1ns/1ps
`include "cop_defines.svh"

module cop_cprs (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  cop_isa_pkg::cpr_addr_t rd_addr1, // crs1
    input  cop_isa_pkg::cpr_addr_t rd_addr2, // crs2
    input  cop_isa_pkg::cpr_addr_t rd_addr3, // crd
    output cop_isa_pkg::word_t     rd_data1,
    output cop_isa_pkg::word_t     rd_data2,
    output cop_isa_pkg::word_t     rd_data3,
    input  cop_bus_pkg::cpr_wr_t   wr        // Single write port
);

    import cop_isa_pkg::*;

    word_t regs [`COP_NCPR];

    // Combinational reads
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];
    assign rd_data3 = regs[rd_addr3];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NCPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wen) begin
            regs[wr.addr] <= wr.wdata;
        end
    end

endmodule

/* exec/cop_palu.sv */
// Packed arithmetic and move unit
`timescale 1ns/1ps

module cop_palu (
    input  cop_isa_pkg::cop_uop_t uop,
    input  cop_isa_pkg::word_t    crs1_data,
    input  cop_isa_pkg::word_t    crs2_data,
    input  logic                  palu_valid,
    output cop_isa_pkg::word_t    result,
    output logic                  cpr_wen     // Write crd
);

    import cop_isa_pkg::*;

    logic       is_sub;
    logic [3:0] lane_start; // Bytes that begin a lane
    word_t      opb;        // Second operand, inverted for sub
    word_t      arith;
    logic       cin;
    logic [8:0] byte_sum;

    assign is_sub = uop.subop == SUB;

    always_comb begin
        case (uop.pw)
            PW8:     lane_start = 4'b1111;
            PW16:    lane_start = 4'b0101;
            default: lane_start = 4'b0001; // One 32-bit lane
        endcase
    end

    // Byte-wise ripple, carry cut at lane boundaries
    always_comb begin
        opb      = is_sub ? ~crs2_data : crs2_data;
        cin      = 1'b0;
        byte_sum = '0;
        arith    = '0;
        for (int i = 0; i < 4; i++) begin
            if (lane_start[i]) begin
                cin = is_sub; // Two's complement +1
            end
            byte_sum = {1'b0, crs1_data[8*i +: 8]} + {1'b0, opb[8*i +: 8]} + 9'(cin);
            arith[8*i +: 8] = byte_sum[7:0];
            cin = byte_sum[8];
        end
    end

    always_comb begin
        case (uop.subop)
            ADD, SUB: result = arith;
            AND:      result = crs1_data & crs2_data;
            OR:       result = crs1_data | crs2_data;
            XOR:      result = crs1_data ^ crs2_data;
            GPR2XCR:  result = uop.gpr_rs1;
            XCR2GPR:  result = crs1_data;   // Goes to GPR via retire
            default:  result = '0;
        endcase
    end

    assign cpr_wen = palu_valid && (uop.subop != XCR2GPR);

endmodule

/* exec/cop_lsu.sv */
// Word load/store unit
`timescale 1ns/1ps

module cop_lsu (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  cop_isa_pkg::cop_uop_t uop,
    input  logic                  lsu_valid,
    input  cop_isa_pkg::word_t    store_data, // crd contents
    output cop_bus_pkg::mem_req_t mem_req,
    input  cop_bus_pkg::mem_rsp_t mem_rsp,
    output logic                  lsu_done,
    output cop_isa_pkg::word_t    load_data,
    output logic                  addr_error,
    output logic                  bus_error
);

    import cop_isa_pkg::*;

    word_t addr;        // Effective address
    logic  start;       // New access this cycle
    logic  xfer_done;   // Bus handshake completes
    logic  cen_q;
    logic  wen_q;
    word_t addr_q;
    word_t wdata_q;

    assign addr       = uop.gpr_rs1 + word_t'({uop.offset, 2'b00});
    assign start      = lsu_valid && !cen_q;
    assign addr_error = start && (addr[1:0] != 2'b00); // No bus access
    assign xfer_done  = cen_q && !mem_rsp.stall;
    assign lsu_done   = addr_error || xfer_done;
    assign bus_error  = xfer_done && mem_rsp.error;
    assign load_data  = mem_rsp.rdata;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cen_q <= 1'b0;
        end else if (start && !addr_error) begin
            cen_q <= 1'b1;  // Raised from cycle after accept
        end else if (xfer_done) begin
            cen_q <= 1'b0;
        end
    end

    // Request payload, held steady while stalled
    always_ff @(posedge g_clk) begin
        if (start) begin
            wen_q   <= uop.subop == SW;
            addr_q  <= addr;
            wdata_q <= store_data;
        end
    end

    assign mem_req = '{cen: cen_q, wen: wen_q, addr: addr_q, wdata: wdata_q};

    // Misaligned addresses never reach the bus
    a_cen_aligned: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cen_q |-> (addr_q[1:0] == 2'b00));

endmodule

/* rtl/cop_retire.sv */
// Writeback and response stage
`timescale 1ns/1ps

module cop_retire (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  cop_isa_pkg::cop_uop_t uop,
    input  logic                  insn_finish,
    input  logic                  palu_valid,
    input  logic                  bad_valid,
    input  cop_isa_pkg::word_t    palu_result,
    input  logic                  palu_cpr_wen,
    input  logic                  lsu_valid,
    input  cop_isa_pkg::word_t    load_data,
    input  logic                  addr_error,
    input  logic                  bus_error,
    output cop_bus_pkg::cpr_wr_t  cpr_wr,
    output cop_bus_pkg::cpu_rsp_t cpu_rsp
);

    import cop_isa_pkg::*;
    import cop_bus_pkg::*;

    logic     is_store;
    logic     load_wen;    // Clean load finishing
    cpu_rsp_t rsp_d;

    assign is_store = uop.subop == SW;
    assign load_wen = lsu_valid && insn_finish && !is_store && !addr_error && !bus_error;

    assign cpr_wr = '{
        wen:   palu_cpr_wen || load_wen,
        addr:  uop.crd,
        wdata: palu_valid ? palu_result : load_data
    };

    always_comb begin
        rsp_d.wen   = palu_valid && (uop.subop == XCR2GPR);
        rsp_d.waddr = uop.rd;
        rsp_d.wdata = palu_result;
        if (bad_valid) begin
            rsp_d.result = BAD_INS;
        end else if (addr_error) begin
            rsp_d.result = is_store ? BAD_SAD : BAD_LAD;
        end else if (bus_error) begin
            rsp_d.result = is_store ? ST_ERR : LD_ERR;
        end else begin
            rsp_d.result = SUCCESS;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cpu_rsp <= '0;
        end else if (insn_finish) begin
            cpu_rsp <= rsp_d; // Stable until next finish
        end
    end

endmodule

/* rtl/cop_top.sv */
// Crypto co-processor top level
`timescale 1ns/1ps

module cop_top (
    input  logic                  g_clk,        // Global clock
    input  logic                  g_resetn,     // Sync reset, active low
    input  logic                  cpu_insn_req, // Instruction request
    output logic                  cop_insn_ack, // Request acknowledge
    input  cop_bus_pkg::cpu_req_t cpu_req,      // Encoding and rs1
    output logic                  cop_insn_rsp, // Instruction finished
    input  logic                  cpu_insn_ack, // Response acknowledge
    output cop_bus_pkg::cpu_rsp_t cpu_rsp,      // GPR writeback and result
    output cop_bus_pkg::mem_req_t mem_req,      // Memory request
    input  cop_bus_pkg::mem_rsp_t mem_rsp       // Memory response
);

    import cop_isa_pkg::*;
    import cop_bus_pkg::*;

    cop_uop_t uop;          // Decoded instruction
    logic     palu_valid;   // Dispatch to packed unit
    logic     lsu_valid;    // Dispatch to load/store unit
    logic     bad_valid;    // Illegal instruction in flight
    logic     insn_finish;  // Instruction completes this cycle
    logic     lsu_done;
    word_t    crs1_data;
    word_t    crs2_data;
    word_t    crd_data;     // Store data
    word_t    palu_result;
    logic     palu_cpr_wen;
    word_t    load_data;
    logic     addr_error;   // Misaligned access
    logic     bus_error;    // Memory reported error
    cpr_wr_t  cpr_wr;       // Merged register write

    cop_issue u_issue (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cop_insn_ack (cop_insn_ack),
        .cpu_req      (cpu_req),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .lsu_done     (lsu_done),
        .uop          (uop),
        .palu_valid   (palu_valid),
        .lsu_valid    (lsu_valid),
        .bad_valid    (bad_valid),
        .insn_finish  (insn_finish)
    );

    cop_cprs u_cprs (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rd_addr1 (uop.crs1),
        .rd_addr2 (uop.crs2),
        .rd_addr3 (uop.crd),  // Store data source
        .rd_data1 (crs1_data),
        .rd_data2 (crs2_data),
        .rd_data3 (crd_data),
        .wr       (cpr_wr)
    );

    cop_palu u_palu (
        .uop        (uop),
        .crs1_data  (crs1_data),
        .crs2_data  (crs2_data),
        .palu_valid (palu_valid),
        .result     (palu_result),
        .cpr_wen    (palu_cpr_wen)
    );

    cop_lsu u_lsu (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .uop        (uop),
        .lsu_valid  (lsu_valid),
        .store_data (crd_data),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .lsu_done   (lsu_done),
        .load_data  (load_data),
        .addr_error (addr_error),
        .bus_error  (bus_error)
    );

    cop_retire u_retire (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .uop          (uop),
        .insn_finish  (insn_finish),
        .palu_valid   (palu_valid),
        .bad_valid    (bad_valid),
        .palu_result  (palu_result),
        .palu_cpr_wen (palu_cpr_wen),
        .lsu_valid    (lsu_valid),
        .load_data    (load_data),
        .addr_error   (addr_error),
        .bus_error    (bus_error),
        .cpr_wr       (cpr_wr),
        .cpu_rsp      (cpu_rsp)
    );

endmodule

/* sim/cop_tb.sv */
// Co-processor directed testbench
`timescale 1ns/1ps
`include "cop_defines.svh"

module cop_tb;

    import cop_isa_pkg::*;
    import cop_bus_pkg::*;

    localparam int          RESET_CYCLES = 16;
    localparam int          INSN_CYCLES  = 200;          // Watchdog budget per instruction
    localparam int          ACK_LIMIT    = 50;
    localparam int          RSP_LIMIT    = 150;          // Loads under heavy stall
    localparam logic [31:0] LFSR_SEED    = 32'h5073614c;
    localparam logic [31:0] LFSR_TAPS    = 32'hA3000000; // Taps 32, 30, 26, 25

    logic     g_clk;
    logic     g_resetn;
    logic     cpu_insn_req;
    logic     cop_insn_ack;
    cpu_req_t cpu_req;
    logic     cop_insn_rsp;
    logic     cpu_insn_ack;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    word_t       mem [256];      // Word memory behind the bus
    logic [31:0] test_lfsr;      // Operand values
    logic [31:0] stall_lfsr;     // Bus stall pattern
    logic        stall_q;        // Bus stalled in the previous cycle
    mem_req_t    stall_req;      // Request seen in the stalled cycle
    int          cen_cycles;     // Cycles with cen high
    int          issued;
    int          mismatch_count;
    int          fail_count;

    cop_top dut0 (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cop_insn_ack (cop_insn_ack),
        .cpu_req      (cpu_req),
        .cop_insn_rsp (cop_insn_rsp),
        .cpu_insn_ack (cpu_insn_ack),
        .cpu_rsp      (cpu_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    always #5 g_clk = ~g_clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], test_lfsr[0]}; // One step per bit
            test_lfsr = lfsr_step(test_lfsr);
        end
        return v;
    endfunction

    function automatic word_t make_insn(input logic [3:0] iclass, input logic [4:0] subop,
                                        input logic [1:0] pw, input logic [4:0] rd,
                                        input cpr_addr_t crs1, input cpr_addr_t crs2);
        return {iclass, subop, 1'b0, pw, crs2, crs1, rd, `COP_OPCODE};
    endfunction

    // Lane-wise reference for packed and bitwise ops
    function automatic word_t op_model(input subop_e op, input pw_e pw, input word_t a,
                                       input word_t b);
        int          w;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        word_t       res;
        case (pw)
            PW8:     w = 8;
            PW16:    w = 16;
            default: w = 32;
        endcase
        mask = (64'd1 << w) - 64'd1;
        res  = '0;
        case (op)
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            default: begin
                for (int i = 0; i < 32 / w; i++) begin
                    la  = ({32'd0, a} >> (i * w)) & mask;
                    lb  = ({32'd0, b} >> (i * w)) & mask;
                    r   = ((op == SUB) ? (la - lb) : (la + lb)) & mask; // Carry dropped
                    res = res | word_t'(r << (i * w));
                end
            end
        endcase
        return res;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_result(input string what, input result_e got, input result_e exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_rsp(input string what, input cpu_rsp_t got, input cpu_rsp_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: got %h expected %h", what, got, exp);
        end
    endtask

    // Bus slave deciding on the falling edge
    always @(negedge g_clk) begin : memory_model
        logic [29:0] widx;
        widx = mem_req.addr[31:2];
        if (stall_q) begin                             // Request must hold while stalled
            check_word("mem_req.cen", word_t'(mem_req.cen), 32'd1);
            check_word("mem_req.wen", word_t'(mem_req.wen), word_t'(stall_req.wen));
            check_word("mem_req.addr", mem_req.addr, stall_req.addr);
            check_word("mem_req.wdata", mem_req.wdata, stall_req.wdata);
        end
        mem_rsp.stall = 1'b0;
        mem_rsp.error = 1'b0;
        if (mem_req.cen) begin
            cen_cycles++;
            mem_rsp.stall = stall_lfsr[0];
            stall_lfsr    = lfsr_step(stall_lfsr);
            mem_rsp.error = widx >= 30'd240;           // Error region
            mem_rsp.rdata = mem[widx[7:0]];
            if (!mem_rsp.stall && mem_req.wen && !mem_rsp.error) begin
                mem[widx[7:0]] = mem_req.wdata;        // Completes at next posedge
            end
        end
        stall_q   = mem_req.cen && mem_rsp.stall;
        stall_req = mem_req;
    end

    // Full request/response handshake with hold cycles of back-pressure
    task automatic run_insn(input word_t enc, input word_t rs1, input int hold,
                            output cpu_rsp_t rsp, output int latency);
        int waited;
        waited      = 0;
        rsp         = '0;
        latency     = 0;
        cpu_req.enc = enc;
        cpu_req.rs1 = rs1;
        cpu_insn_req = 1'b1;
        issued++;
        while (!cop_insn_ack && waited < ACK_LIMIT) begin
            @(negedge g_clk);
            waited++;
        end
        if (!cop_insn_ack) begin
            fail_count++;
            $display("No acknowledge for instruction %h", enc);
            cpu_insn_req = 1'b0;
        end else begin
            @(negedge g_clk);             // Accepted at the edge just passed
            cpu_insn_req = 1'b0;
            latency      = 1;
            while (!cop_insn_rsp && latency < RSP_LIMIT) begin
                @(negedge g_clk);
                latency++;
            end
            if (!cop_insn_rsp) begin
                fail_count++;
                $display("No response for instruction %h", enc);
            end else begin
                rsp = cpu_rsp;
                if (cop_insn_ack) begin
                    fail_count++;
                    $display("Acknowledge high while a response is pending");
                end
                cpu_insn_req = hold > 0;  // Offered again but never taken
                repeat (hold) begin
                    @(negedge g_clk);
                    if (!cop_insn_rsp || cop_insn_ack) begin
                        fail_count++;
                        $display("Handshake changed during back-pressure");
                    end
                    check_rsp("cpu_rsp", cpu_rsp, rsp);
                end
                cpu_insn_ack = 1'b1;
                @(negedge g_clk);
                cpu_insn_ack = 1'b0;
                cpu_insn_req = 1'b0;
                if (cop_insn_rsp || !cop_insn_ack) begin
                    fail_count++;
                    $display("Handshake wrong in the cycle after retire");
                end
            end
        end
    endtask

    task automatic issue_expect(input word_t enc, input word_t rs1, input result_e exp,
                                input int hold, output int lat);
        cpu_rsp_t rsp;
        run_insn(enc, rs1, hold, rsp, lat);
        check_result("cpu_rsp.result", rsp.result, exp);
        check_word("cpu_rsp.wen", word_t'(rsp.wen), '0);
    endtask

    task automatic write_cpr(input cpr_addr_t r, input word_t v);
        int lat;
        issue_expect(make_insn(MOVE, GPR2XCR, PW32, {1'b0, r}, 4'd0, 4'd0), v, SUCCESS, 0, lat);
        check_word("GPR2XCR latency", word_t'(lat), 32'd1);
    endtask

    task automatic read_cpr(input cpr_addr_t r, input gpr_addr_t rd, input word_t exp,
                            input int hold);
        cpu_rsp_t rsp;
        cpu_rsp_t exp_rsp;
        int       lat;
        exp_rsp.wen    = 1'b1;
        exp_rsp.waddr  = rd;
        exp_rsp.wdata  = exp;
        exp_rsp.result = SUCCESS;
        run_insn(make_insn(MOVE, XCR2GPR, PW32, rd, r, 4'd0), rand_bits(32), hold, rsp, lat);
        check_rsp("XCR2GPR cpu_rsp", rsp, exp_rsp);
        check_word("XCR2GPR latency", word_t'(lat), 32'd1);
    endtask

    task automatic reset_state();
        repeat (RESET_CYCLES) @(negedge g_clk);
        check_word("cop_insn_ack", word_t'(cop_insn_ack), '0);
        check_word("cop_insn_rsp", word_t'(cop_insn_rsp), '0);
        check_word("mem_req.cen", word_t'(mem_req.cen), '0);
        check_rsp("cpu_rsp", cpu_rsp, '0);
        g_resetn = 1'b1;
        @(negedge g_clk);                 // One cycle in IDLE
        check_word("cop_insn_ack", word_t'(cop_insn_ack), 32'd1);
    endtask

    task automatic move_round_trip();
        word_t     v;
        cpr_addr_t c;
        repeat (3) begin
            v = rand_bits(32);
            c = cpr_addr_t'(rand_bits(4));
            write_cpr(c, v);
            read_cpr(c, gpr_addr_t'(rand_bits(5)), v, 0);
        end
    endtask

    task automatic packed_ops();
        word_t  a;
        word_t  b;
        int     lat;
        pw_e    pw;
        subop_e op;
        for (int p = 0; p < 3; p++) begin
            pw = pw_e'(p);
            for (int round = 0; round < 2; round++) begin
                a = (round == 0) ? 32'h80FF7F01 : rand_bits(32); // Fixed lane carries first
                b = (round == 0) ? 32'h01010181 : rand_bits(32);
                write_cpr(4'd1, a);
                write_cpr(4'd2, b);
                for (int k = 0; k < 5; k++) begin
                    op = subop_e'(k);     // ADD through XOR
                    issue_expect(make_insn((k < 2) ? PACKED_ARITH : BITWISE, op, pw, 5'd3,
                                           4'd1, 4'd2), 32'd0, SUCCESS, 0, lat);
                    check_word("op latency", word_t'(lat), 32'd1);
                    read_cpr(4'd3, 5'd9, op_model(op, pw, a, b), 0);
                end
            end
        end
    endtask

    task automatic store_then_load();
        int    base;
        int    off;
        int    lat;
        word_t v;
        repeat (4) begin
            base = int'(rand_bits(7));    // Stays below the error region
            off  = int'(rand_bits(4));
            v    = rand_bits(32);
            write_cpr(4'd7, v);
            issue_expect(make_insn(LOADSTORE, SW, PW32, 5'd7, 4'd0, cpr_addr_t'(off)),
                         word_t'(base) << 2, SUCCESS, 0, lat);
            if (lat < 2) begin
                fail_count++;
                $display("Store finished without a bus transfer");
            end
            check_word("memory word", mem[base + off], v);
            issue_expect(make_insn(LOADSTORE, LW, PW32, 5'd9, 4'd0, cpr_addr_t'(off)),
                         word_t'(base) << 2, SUCCESS, 0, lat);
            check_word("memory word after load", mem[base + off], v);
            read_cpr(4'd9, 5'd10, v, 0);
        end
    endtask

    task automatic error_codes();
        int    c;
        int    lat;
        word_t marker;
        c = cen_cycles;
        issue_expect(make_insn(LOADSTORE, LW, PW32, 5'd4, 4'd0, 4'd1), 32'h101, BAD_LAD, 0, lat);
        issue_expect(make_insn(LOADSTORE, SW, PW32, 5'd4, 4'd0, 4'd0), 32'h202, BAD_SAD, 0, lat);
        check_word("cen cycles", word_t'(cen_cycles), word_t'(c));
        marker = rand_bits(32);
        write_cpr(4'd11, marker);
        issue_expect(make_insn(LOADSTORE, LW, PW32, 5'd11, 4'd0, 4'd2), 32'h3C0, LD_ERR, 0, lat);
        read_cpr(4'd11, 5'd12, marker, 0);  // Failed load leaves crd alone
        issue_expect(make_insn(LOADSTORE, SW, PW32, 5'd11, 4'd0, 4'd5), 32'h3C0, ST_ERR, 0, lat);
        issue_expect(make_insn(4'd9, ADD, PW32, 5'd3, 4'd1, 4'd2), 32'd0, BAD_INS, 0, lat);
        issue_expect(make_insn(PACKED_ARITH, ADD, 2'b11, 5'd3, 4'd1, 4'd2), 32'd0, BAD_INS, 0,
                     lat);
        issue_expect(make_insn(BITWISE, ADD, PW32, 5'd3, 4'd1, 4'd2), 32'd0, BAD_INS, 0, lat);
        issue_expect(make_insn(PACKED_ARITH, SUB, PW16, 5'd3, 4'd1, 4'd2) ^ 32'h1, 32'd0, BAD_INS,
                     0, lat);                 // Wrong opcode
    endtask

    task automatic back_pressure();
        word_t v;
        word_t exp;
        int    lat;
        v = rand_bits(32);
        write_cpr(4'd12, v);
        read_cpr(4'd12, 5'd21, v, 3 + int'(rand_bits(3)));
        exp = mem[16];
        issue_expect(make_insn(LOADSTORE, LW, PW32, 5'd13, 4'd0, 4'd0), 32'h40, SUCCESS,
                     3 + int'(rand_bits(3)), lat);
        read_cpr(4'd13, 5'd22, exp, 0);
    endtask

    initial begin
        g_clk          = 1'b0;
        g_resetn       = 1'b0;
        cpu_insn_req   = 1'b0;
        cpu_insn_ack   = 1'b0;
        cpu_req        = '0;
        mem_rsp        = '0;
        test_lfsr      = LFSR_SEED;
        stall_lfsr     = LFSR_SEED;
        stall_q        = 1'b0;
        cen_cycles     = 0;
        issued         = 0;
        mismatch_count = 0;
        fail_count     = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
        end
        reset_state();
        move_round_trip();
        packed_ops();
        store_then_load();
        error_codes();
        back_pressure();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Budget grows with each issued instruction
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < RESET_CYCLES + INSN_CYCLES * (issued + 1)) begin
            @(posedge g_clk);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles, %0d mismatches, %0d other failures",
                 cycles, mismatch_count, fail_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/cop_isa_pkg.sv
common/cop_bus_pkg.sv
issue/cop_issue.sv
exec/cop_cprs.sv
exec/cop_palu.sv
exec/cop_lsu.sv
rtl/cop_retire.sv
rtl/cop_top.sv
sim/cop_tb.sv

/* Bender.yml */
package:
  name: cop

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cop_isa_pkg.sv
      - common/cop_bus_pkg.sv
      - issue/cop_issue.sv
      - exec/cop_cprs.sv
      - exec/cop_palu.sv
      - exec/cop_lsu.sv
      - rtl/cop_retire.sv
      - rtl/cop_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/cop_tb.sv
